/* Bender.yml */
package:
  name: crc_ahb

sources:
  - hdl/crc_pkg.sv
  - hdl/host_interface.sv
  - hdl/crc_regs.sv
  - hdl/input_buffer.sv
  - hdl/crc_engine.sv
  - hdl/crc_ahb_top.sv
  - target: test
    files:
      - bench/crc_ahb_tb.sv

/* all.f */
hdl/crc_pkg.sv
hdl/host_interface.sv
hdl/crc_regs.sv
hdl/input_buffer.sv
hdl/crc_engine.sv
hdl/crc_ahb_top.sv
bench/crc_ahb_tb.sv

/* bench/crc_ahb_tb.sv */
`timescale 1ns/1ps

module crc_ahb_tb;
	import crc_pkg::*;

	// Step kinds in the stimulus table
	typedef enum logic [1:0] {
		OP_WRITE     = 2'd0,
		OP_READ      = 2'd1,
		OP_READ_BACK = 2'd2,
		OP_READ_CRC  = 2'd3
	} op_e;

	// One table row
	// Only OP_READ uses the expected field
	typedef struct packed {
		op_e       op;
		reg_addr_e offset;
		bus_size_e size;
		logic      rnd;
		crc_word_t data;
		crc_word_t expected;
	} stim_t;

	logic       HCLK = 1'b0;
	logic       HRESETn;
	logic       HSElx;
	logic [31:0] HADDR;
	htrans_e    HTRANS;
	logic       HWRITE;
	logic [2:0] HSIZE;
	crc_word_t  HWDATA;
	logic       HREADY;
	crc_word_t  HRDATA;
	logic       HREADYOUT;
	hresp_e     HRESP;

	stim_t      stim_q[$];
	logic       stim_ready = 1'b0;
	integer     seed;

	// Reference model state
	crc_word_t  model_crc;
	crc_word_t  model_init;
	crc_word_t  model_poly;
	crc_cfg_t   model_cfg;
	crc_word_t  shadow [8];

	crc_ahb_top u_crc_ahb_top
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSIZE     (HSIZE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	// 100 MHz
	always #5 HCLK = ~HCLK;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input crc_word_t got, input crc_word_t want, input string what);
		if (got !== want)
		begin
			$display("CHECK FAILED at time %0d ns: %s, got %h expected %h",
				$time, what, got, want);
			$display("=== FAIL ===");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic check_resp(input hresp_e got, input hresp_e want, input string what);
		if (got !== want)
		begin
			$display("CHECK FAILED at time %0d ns: %s, got %0d expected %0d",
				$time, what, got, want);
			$display("=== FAIL ===");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// AHB-Lite driver, one transfer at a time
	////////////////////////////////////////////////////////////////////////////

	// Address phase then data phase held until HREADYOUT
	task automatic ahb_write(input reg_addr_e off, input bus_size_e size, input crc_word_t d);
		@(negedge HCLK);
		HSElx  = 1'b1;
		HADDR  = {27'h0, off, 2'b00};
		HTRANS = NON_SEQ;
		HWRITE = 1'b1;
		HSIZE  = size;
		@(negedge HCLK);
		HSElx  = 1'b0;
		HTRANS = IDLE;
		HWRITE = 1'b0;
		HWDATA = d;
		// Wait states show up as HREADYOUT low
		while (!HREADYOUT)
			@(negedge HCLK);
		check_resp(HRESP, OK, "write response");
	endtask

	task automatic ahb_read(input reg_addr_e off, output crc_word_t d);
		@(negedge HCLK);
		HSElx  = 1'b1;
		HADDR  = {27'h0, off, 2'b00};
		HTRANS = NON_SEQ;
		HWRITE = 1'b0;
		HSIZE  = SIZE_WORD;
		@(negedge HCLK);
		HSElx  = 1'b0;
		HTRANS = IDLE;
		while (!HREADYOUT)
			@(negedge HCLK);
		// Read data is valid in the last data phase cycle
		d = HRDATA;
		check_resp(HRESP, OK, "read response");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference CRC model
	////////////////////////////////////////////////////////////////////////////

	function automatic int poly_width(input poly_size_e p);
		case (p)
			P16:     return 16;
			P8:      return 8;
			P7:      return 7;
			default: return 32;
		endcase
	endfunction

	function automatic crc_word_t width_mask(input int w);
		if (w >= 32)
			return 32'hFFFF_FFFF;
		return (32'h1 << w) - 32'h1;
	endfunction

	// Mirror each group of g bytes within the n written bytes
	function automatic crc_word_t reflect_groups(input crc_word_t d, input int n, input int g);
		crc_word_t r;
		int        base;
		r = d;
		for (int k = 0; k < n; k += g)
		begin
			base = 8 * k;
			for (int j = 0; j < 8 * g; j++)
				r[base + j] = d[base + 8 * g - 1 - j];
		end
		return r;
	endfunction

	// Plain shift register CRC with data MSB first
	function automatic crc_word_t crc_byte(input crc_word_t c, input logic [7:0] b,
		input crc_word_t poly, input int w);
		crc_word_t m;
		crc_word_t s;
		logic      fb;
		m = width_mask(w);
		s = c;
		for (int i = 7; i >= 0; i--)
		begin
			fb = s[w - 1] ^ b[i];
			s  = (s << 1) & m;
			if (fb)
				s = s ^ (poly & m);
		end
		return s;
	endfunction

	function automatic crc_word_t mirror_word(input crc_word_t d);
		crc_word_t r;
		for (int i = 0; i < 32; i++)
			r[31 - i] = d[i];
		return r;
	endfunction

	function automatic crc_word_t expected_crc();
		if (model_cfg.rev_out)
			return mirror_word(model_crc);
		return model_crc;
	endfunction

	// IDR is one byte wide and CR keeps bits 7 to 3
	function automatic crc_word_t readback_value(input reg_addr_e off);
		case (off)
			CRC_IDR: return shadow[off] & 32'h0000_00FF;
			CRC_CR:  return shadow[off] & 32'h0000_00F8;
			default: return shadow[off];
		endcase
	endfunction

	// Track every write the way the register map defines it
	task automatic model_write(input reg_addr_e off, input bus_size_e size, input crc_word_t d);
		int        n;
		int        span;
		int        w;
		crc_word_t v;
		shadow[off] = d;
		case (off)
			CRC_INIT: model_init = d;
			CRC_POL:  model_poly = d;
			CRC_CR:
			begin
				model_cfg = crc_cfg_t'(d[7:3]);
				// Bit 0 restarts from INIT at the new width
				if (d[0])
					model_crc = model_init & width_mask(poly_width(model_cfg.poly_size));
			end
			CRC_DR:
			begin
				case (size)
					SIZE_BYTE: n = 1;
					SIZE_HALF: n = 2;
					default:   n = 4;
				endcase
				case (model_cfg.rev_in)
					REV_BYTE: span = 1;
					REV_HALF: span = 2;
					REV_WORD: span = 4;
					default:  span = 0;
				endcase
				// Narrow writes only reverse the bytes they carry
				if (span > n)
					span = n;
				v = (span == 0) ? d : reflect_groups(d, n, span);
				w = poly_width(model_cfg.poly_size);
				// Lowest byte enters first
				for (int k = 0; k < n; k++)
					model_crc = crc_byte(model_crc, v[8 * k +: 8], model_poly, w);
			end
			default: ;
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic add_step(input op_e op, input reg_addr_e off, input bus_size_e size,
		input logic rnd, input crc_word_t data, input crc_word_t expected);
		stim_t s;
		s.op       = op;
		s.offset   = off;
		s.size     = size;
		s.rnd      = rnd;
		s.data     = data;
		s.expected = expected;
		stim_q.push_back(s);
	endtask

	task automatic build_table();
		// Reset values
		add_step(OP_READ, CRC_INIT, SIZE_WORD, 1'b0, 32'h0, 32'hFFFF_FFFF);
		add_step(OP_READ, CRC_POL, SIZE_WORD, 1'b0, 32'h0, 32'h04C1_1DB7);
		add_step(OP_READ, CRC_IDR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		add_step(OP_READ, CRC_CR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		add_step(OP_READ, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'hFFFF_FFFF);
		// Register read-back with random data
		add_step(OP_WRITE, CRC_INIT, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_BACK, CRC_INIT, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_POL, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_BACK, CRC_POL, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_IDR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_BACK, CRC_IDR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'hFF, 32'h0);
		add_step(OP_READ_BACK, CRC_CR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		// Back to CRC-32 defaults with random words
		add_step(OP_WRITE, CRC_POL, SIZE_WORD, 1'b0, 32'h04C1_1DB7, 32'h0);
		add_step(OP_WRITE, CRC_INIT, SIZE_WORD, 1'b0, 32'hFFFF_FFFF, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h01, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_CRC, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		// CRC-32/MPEG-2 of the check string 123456789
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h01, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b0, 32'h3433_3231, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b0, 32'h3837_3635, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_BYTE, 1'b0, 32'h0000_0039, 32'h0);
		add_step(OP_READ, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0376_E6E7);
		// 16 bit polynomial with mixed sizes
		add_step(OP_WRITE, CRC_POL, SIZE_WORD, 1'b0, 32'h0000_1021, 32'h0);
		add_step(OP_WRITE, CRC_INIT, SIZE_WORD, 1'b0, 32'h0000_FFFF, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h09, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_HALF, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_BYTE, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_CRC, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		// 8 bit polynomial
		add_step(OP_WRITE, CRC_POL, SIZE_WORD, 1'b0, 32'h0000_0007, 32'h0);
		add_step(OP_WRITE, CRC_INIT, SIZE_WORD, 1'b0, 32'h0000_0000, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h11, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_BYTE, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_HALF, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_CRC, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		// 7 bit polynomial
		add_step(OP_WRITE, CRC_POL, SIZE_WORD, 1'b0, 32'h0000_0009, 32'h0);
		add_step(OP_WRITE, CRC_INIT, SIZE_WORD, 1'b0, 32'h0000_007F, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h19, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_BYTE, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_CRC, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		// Reversal modes on CRC-32
		add_step(OP_WRITE, CRC_POL, SIZE_WORD, 1'b0, 32'h04C1_1DB7, 32'h0);
		add_step(OP_WRITE, CRC_INIT, SIZE_WORD, 1'b0, 32'hFFFF_FFFF, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h81, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_CRC, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h21, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_HALF, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_CRC, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'hC1, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_BYTE, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_CRC, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h61, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_HALF, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_CRC, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
		// Check string again as reflected CRC-32 without final XOR
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'hA1, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b0, 32'h3433_3231, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b0, 32'h3837_3635, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_BYTE, 1'b0, 32'h0000_0039, 32'h0);
		add_step(OP_READ, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h340B_C6D9);
		// Restart mid stream from a fresh INIT
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h01, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_INIT, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_CR, SIZE_WORD, 1'b0, 32'h01, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_WORD, 1'b1, 32'h0, 32'h0);
		add_step(OP_WRITE, CRC_DR, SIZE_HALF, 1'b1, 32'h0, 32'h0);
		add_step(OP_READ_CRC, CRC_DR, SIZE_WORD, 1'b0, 32'h0, 32'h0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		stim_t     s;
		crc_word_t d;
		crc_word_t rd;
		crc_word_t want;
		string     what;
		seed    = 32'h9513;
		HRESETn = 1'b0;
		HSElx   = 1'b0;
		HADDR   = 32'h0;
		HTRANS  = IDLE;
		HWRITE  = 1'b0;
		HSIZE   = SIZE_WORD;
		HWDATA  = 32'h0;
		// Single slave with no other data phase to wait on
		HREADY  = 1'b1;
		model_crc  = 32'hFFFF_FFFF;
		model_init = 32'hFFFF_FFFF;
		model_poly = 32'h04C1_1DB7;
		model_cfg  = crc_cfg_t'(5'b00000);
		for (int k = 0; k < 8; k++)
			shadow[k] = 32'h0;
		build_table();
		stim_ready = 1'b1;
		repeat (4) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;
		for (int i = 0; i < stim_q.size(); i++)
		begin
			s    = stim_q[i];
			d    = s.rnd ? crc_word_t'($random(seed)) : s.data;
			what = $sformatf("step %0d offset %0d", i, s.offset);
			case (s.op)
				OP_WRITE:
				begin
					ahb_write(s.offset, s.size, d);
					model_write(s.offset, s.size, d);
				end
				OP_READ:
				begin
					ahb_read(s.offset, rd);
					check_word(rd, s.expected, what);
				end
				OP_READ_BACK:
				begin
					want = readback_value(s.offset);
					ahb_read(s.offset, rd);
					check_word(rd, want, what);
				end
				default:
				begin
					want = expected_crc();
					ahb_read(s.offset, rd);
					check_word(rd, want, what);
				end
			endcase
		end
		$display("=== PASS ===");
		$finish;
	end

	// Twenty cycles per table step is far more than any step needs
	initial
	begin
		wait (stim_ready);
		repeat (stim_q.size() * 20) @(posedge HCLK);
		$display("Run timed out, the DUT did not complete within %0d clock cycles",
			stim_q.size() * 20);
		$display("=== FAIL ===");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* hdl/crc_ahb_top.sv */
`timescale 1ns/1ps

module crc_ahb_top
#(
	parameter crc_pkg::crc_word_t RESET_INIT = 32'hFFFF_FFFF,
	parameter crc_pkg::crc_word_t RESET_POLY = 32'h04C1_1DB7
)
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  logic               HSElx,
	input  logic [31:0]        HADDR,
	input  crc_pkg::htrans_e   HTRANS,
	input  logic               HWRITE,
	input  logic [2:0]         HSIZE,
	input  crc_pkg::crc_word_t HWDATA,
	input  logic               HREADY,
	output crc_pkg::crc_word_t HRDATA,
	output logic               HREADYOUT,
	output crc_pkg::hresp_e    HRESP
);
	import crc_pkg::*;

	// Host to register and buffer side
	reg_wr_t    wr;
	crc_cfg_t   cfg;
	logic       reset_chain;

	// Status and data back to the host
	crc_word_t  crc_value;
	crc_word_t  init_value;
	crc_word_t  poly_value;
	logic [7:0] idr_value;
	logic       buffer_full;
	logic       busy;
	logic       reset_pending;

	// Buffer to engine
	byte_beat_t beat;

	////////////////////////////////////////////////////////////////////////////
	// Bus slave and control register
	////////////////////////////////////////////////////////////////////////////

	host_interface u_host_interface
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.HSElx         (HSElx),
		.HADDR         (HADDR),
		.HTRANS        (HTRANS),
		.HWRITE        (HWRITE),
		.HSIZE         (HSIZE),
		.HWDATA        (HWDATA),
		.HREADY        (HREADY),
		.HRDATA        (HRDATA),
		.HREADYOUT     (HREADYOUT),
		.HRESP         (HRESP),
		.wr            (wr),
		.cfg           (cfg),
		.reset_chain   (reset_chain),
		.crc_value     (crc_value),
		.init_value    (init_value),
		.poly_value    (poly_value),
		.idr_value     (idr_value),
		.buffer_full   (buffer_full),
		.busy          (busy),
		.reset_pending (reset_pending)
	);

	////////////////////////////////////////////////////////////////////////////
	// Data registers and input path, side by side
	////////////////////////////////////////////////////////////////////////////

	crc_regs
	#(
		.RESET_INIT (RESET_INIT),
		.RESET_POLY (RESET_POLY)
	)
	u_crc_regs
	(
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.wr         (wr),
		.init_value (init_value),
		.poly_value (poly_value),
		.idr_value  (idr_value)
	);

	input_buffer u_input_buffer
	(
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.wr          (wr),
		.rev_in      (cfg.rev_in),
		.beat        (beat),
		.buffer_full (buffer_full)
	);

	// Engine joins both paths
	crc_engine u_crc_engine
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.cfg           (cfg),
		.reset_chain   (reset_chain),
		.init_value    (init_value),
		.poly_value    (poly_value),
		.beat          (beat),
		.crc_value     (crc_value),
		.busy          (busy),
		.reset_pending (reset_pending)
	);

endmodule

/* hdl/crc_engine.sv */
`timescale 1ns/1ps

module crc_engine
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  crc_pkg::crc_cfg_t   cfg,
	input  logic                reset_chain,
	input  crc_pkg::crc_word_t  init_value,
	input  crc_pkg::crc_word_t  poly_value,
	input  crc_pkg::byte_beat_t beat,
	output crc_pkg::crc_word_t  crc_value,
	output logic                busy,
	output logic                reset_pending
);
	import crc_pkg::*;

	// CRC state, right aligned in the word
	crc_word_t  crc_q;
	logic       reset_pending_q;

	crc_word_t  mask;
	logic [4:0] top;
	crc_word_t  crc_next;
	crc_word_t  crc_rev;

	////////////////////////////////////////////////////////////////////////////
	// Width selection
	////////////////////////////////////////////////////////////////////////////

	// Mask of valid bits and index of the CRC MSB
	always_comb
	begin
		case (cfg.poly_size)
			P16:
			begin
				mask = 32'h0000_FFFF;
				top  = 5'd15;
			end
			P8:
			begin
				mask = 32'h0000_00FF;
				top  = 5'd7;
			end
			P7:
			begin
				mask = 32'h0000_007F;
				top  = 5'd6;
			end
			default:
			begin
				mask = 32'hFFFF_FFFF;
				top  = 5'd31;
			end
		endcase
	end

	// Eight shift steps, data MSB first
	// Works for widths below eight bits too
	function automatic crc_word_t crc_update(input crc_word_t crc_in, input logic [7:0] data,
		input crc_word_t poly, input crc_word_t msk, input logic [4:0] msb);
		crc_word_t c;
		logic      fb;
		c = crc_in;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[msb] ^ data[i];
			c  = (c << 1) & msk;
			if (fb)
				c = c ^ (poly & msk);
		end
		return c;
	endfunction

	assign crc_next = crc_update(crc_q, beat.data, poly_value, mask, top);

	////////////////////////////////////////////////////////////////////////////
	// CRC register
	////////////////////////////////////////////////////////////////////////////

	// Restart lands one cycle after the CR write
	// A restart wins over a beat in the same cycle
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_q           <= init_value;
			reset_pending_q <= 1'b0;
		end
		else
		begin
			reset_pending_q <= reset_chain;
			if (reset_pending_q)
				crc_q <= init_value & mask;
			else if (beat.valid)
				crc_q <= crc_next;
		end
	end

	assign reset_pending = reset_pending_q;

	// A beat is in flight in the cycle it is presented
	assign busy = beat.valid;

	// Output reversal over the full word
	assign crc_rev   = {<<{crc_q}};
	assign crc_value = cfg.rev_out ? crc_rev : crc_q;

endmodule

/* hdl/crc_pkg.sv */
package crc_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Basic data types
	////////////////////////////////////////////////////////////////////////////

	// One bus word, also the width of every CRC related value
	typedef logic [31:0] crc_word_t;

	// Register offsets as seen on HADDR[4:2]
	typedef enum logic [2:0] {
		CRC_DR   = 3'd0,
		CRC_IDR  = 3'd1,
		CRC_CR   = 3'd2,
		CRC_INIT = 3'd4,
		CRC_POL  = 3'd5
	} reg_addr_e;

	// Word address bits used for register decode
	localparam int ADDR_MSB = 4;
	localparam int ADDR_LSB = 2;

	////////////////////////////////////////////////////////////////////////////
	// AHB-Lite encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE    = 2'b00,
		BUSY    = 2'b01,
		NON_SEQ = 2'b10,
		SEQ     = 2'b11
	} htrans_e;

	typedef enum logic {
		OK    = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	// Same encoding as HSIZE
	typedef enum logic [2:0] {
		SIZE_BYTE = 3'b000,
		SIZE_HALF = 3'b001,
		SIZE_WORD = 3'b010
	} bus_size_e;

	////////////////////////////////////////////////////////////////////////////
	// Configuration held in the control register
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		P32 = 2'b00,
		P16 = 2'b01,
		P8  = 2'b10,
		P7  = 2'b11
	} poly_size_e;

	// Span of input bit reversal
	typedef enum logic [1:0] {
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_e;

	// Field order follows CR bits 7 down to 3
	typedef struct packed {
		logic       rev_out;
		rev_in_e    rev_in;
		poly_size_e poly_size;
	} crc_cfg_t;

	// Control register value after reset
	localparam crc_cfg_t CFG_RESET = '{rev_out: 1'b0, rev_in: REV_NONE, poly_size: P32};

	// One register write from the data phase
	typedef struct packed {
		crc_word_t data;
		bus_size_e size;
		logic      buffer_en;
		logic      init_en;
		logic      poly_en;
		logic      idr_en;
	} reg_wr_t;

	// One byte handed from the input buffer to the engine
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} byte_beat_t;

endpackage

/* hdl/crc_regs.sv */
`timescale 1ns/1ps

module crc_regs
#(
	parameter crc_pkg::crc_word_t RESET_INIT = 32'hFFFF_FFFF,
	parameter crc_pkg::crc_word_t RESET_POLY = 32'h04C1_1DB7
)
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  crc_pkg::reg_wr_t   wr,
	output crc_pkg::crc_word_t init_value,
	output crc_pkg::crc_word_t poly_value,
	output logic [7:0]         idr_value
);

	////////////////////////////////////////////////////////////////////////////
	// Initial value register
	////////////////////////////////////////////////////////////////////////////

	// Loaded into the engine on every chain reset
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			init_value <= RESET_INIT;
		else if (wr.init_en)
			init_value <= wr.data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Polynomial register
	////////////////////////////////////////////////////////////////////////////

	// Full word stored, the engine masks it to the selected width
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			poly_value <= RESET_POLY;
		else if (wr.poly_en)
			poly_value <= wr.data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Scratch register
	////////////////////////////////////////////////////////////////////////////

	// Free byte for software, no effect on the CRC
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			idr_value <= 8'h00;
		else if (wr.idr_en)
			idr_value <= wr.data[7:0];
	end

endmodule

/* hdl/host_interface.sv */
`timescale 1ns/1ps

module host_interface
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  logic               HSElx,
	input  logic [31:0]        HADDR,
	input  crc_pkg::htrans_e   HTRANS,
	input  logic               HWRITE,
	input  logic [2:0]         HSIZE,
	input  crc_pkg::crc_word_t HWDATA,
	input  logic               HREADY,
	output crc_pkg::crc_word_t HRDATA,
	output logic               HREADYOUT,
	output crc_pkg::hresp_e    HRESP,
	output crc_pkg::reg_wr_t   wr,
	output crc_pkg::crc_cfg_t  cfg,
	output logic               reset_chain,
	input  crc_pkg::crc_word_t crc_value,
	input  crc_pkg::crc_word_t init_value,
	input  crc_pkg::crc_word_t poly_value,
	input  logic [7:0]         idr_value,
	input  logic               buffer_full,
	input  logic               busy,
	input  logic               reset_pending
);
	import crc_pkg::*;

	// Address phase copy held through the data phase
	reg_addr_e addr_q;
	bus_size_e size_q;
	htrans_e   trans_q;
	logic      write_q;
	logic      sel_q;

	// Control register
	crc_cfg_t  cr_q;

	logic      sample_bus;
	logic      active;
	logic      dr_wr;
	logic      dr_rd;
	logic      init_wr;
	logic      read_wait;

	////////////////////////////////////////////////////////////////////////////
	// Address phase capture
	////////////////////////////////////////////////////////////////////////////

	// Bus is sampled only when the previous data phase has completed
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			sel_q   <= 1'b0;
			write_q <= 1'b0;
			trans_q <= IDLE;
		end
		else if (sample_bus)
		begin
			sel_q   <= HSElx;
			write_q <= HWRITE;
			trans_q <= HTRANS;
		end
	end

	// Register offset and size of the transfer in flight
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			addr_q <= reg_addr_e'(HADDR[ADDR_MSB:ADDR_LSB]);
			size_q <= bus_size_e'(HSIZE);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode and wait states
	////////////////////////////////////////////////////////////////////////////

	// Only NON_SEQ transfers do anything
	assign active  = sel_q && (trans_q == NON_SEQ);
	assign dr_wr   = active && write_q && (addr_q == CRC_DR);
	assign dr_rd   = active && !write_q && (addr_q == CRC_DR);
	assign init_wr = active && write_q && (addr_q == CRC_INIT);

	// DR read waits until every byte has gone through the engine
	assign read_wait = buffer_full || busy;

	// Stall DR writes on a full buffer
	// Stall INIT writes while the engine is loading the old value
	assign HREADYOUT = !((dr_wr && buffer_full) ||
	                     (dr_rd && read_wait) ||
	                     (init_wr && reset_pending));

	// No error responses in this slave
	assign HRESP = OK;

	// Enables fire once in the last cycle of the data phase
	always_comb
	begin
		wr.data      = HWDATA;
		wr.size      = size_q;
		wr.buffer_en = dr_wr && HREADYOUT;
		wr.init_en   = init_wr && HREADYOUT;
		wr.poly_en   = active && write_q && (addr_q == CRC_POL);
		wr.idr_en    = active && write_q && (addr_q == CRC_IDR);
	end

	////////////////////////////////////////////////////////////////////////////
	// Control register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_q <= CFG_RESET;
		else if (active && write_q && (addr_q == CRC_CR))
			cr_q <= crc_cfg_t'(HWDATA[7:3]);
	end

	assign cfg = cr_q;

	// CR bit 0 is self clearing and only requests the restart
	assign reset_chain = active && write_q && (addr_q == CRC_CR) && HWDATA[0];

	// Read data follows the registered address
	always_comb
	begin
		case (addr_q)
			CRC_DR:   HRDATA = crc_value;
			CRC_IDR:  HRDATA = {24'h0, idr_value};
			CRC_CR:   HRDATA = {24'h0, cr_q, 3'b000};
			CRC_INIT: HRDATA = init_value;
			CRC_POL:  HRDATA = poly_value;
			default:  HRDATA = '0;
		endcase
	end

endmodule

/* hdl/input_buffer.sv */
`timescale 1ns/1ps

module input_buffer
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  crc_pkg::reg_wr_t    wr,
	input  crc_pkg::rev_in_e    rev_in,
	output crc_pkg::byte_beat_t beat,
	output logic                buffer_full
);
	import crc_pkg::*;

	// Stored word, shifted down one byte per beat
	crc_word_t  data_q;
	// Bytes still to issue
	logic [2:0] count_q;

	rev_in_e    rev_eff;
	crc_word_t  data_rev;
	logic [2:0] count_in;

	// Reversal never reaches past the written bytes
	// A wider span on a narrow write acts on the written bytes only
	function automatic rev_in_e clamp_rev(input rev_in_e mode, input bus_size_e size);
		rev_in_e m;
		m = mode;
		if (size == SIZE_BYTE && mode != REV_NONE)
			m = REV_BYTE;
		else if (size == SIZE_HALF && mode == REV_WORD)
			m = REV_HALF;
		return m;
	endfunction

	// Mirror bits inside each byte, halfword or the whole word
	function automatic crc_word_t rev_bits(input crc_word_t d, input rev_in_e mode);
		crc_word_t r;
		r = d;
		for (int i = 0; i < 32; i++)
		begin
			case (mode)
				REV_BYTE: r[i] = d[(i & ~7) + 7 - (i & 7)];
				REV_HALF: r[i] = d[(i & ~15) + 15 - (i & 15)];
				REV_WORD: r[i] = d[31 - i];
				default:  r[i] = d[i];
			endcase
		end
		return r;
	endfunction

	assign rev_eff  = clamp_rev(rev_in, wr.size);
	assign data_rev = rev_bits(wr.data, rev_eff);

	// Beat count from the transfer size
	always_comb
	begin
		case (wr.size)
			SIZE_BYTE: count_in = 3'd1;
			SIZE_HALF: count_in = 3'd2;
			default:   count_in = 3'd4;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Capture and byte shifter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count_q <= 3'd0;
		else if (wr.buffer_en)
			count_q <= count_in;
		else if (count_q != 3'd0)
			count_q <= count_q - 3'd1;
	end

	// Low byte goes first
	always_ff @(posedge HCLK)
	begin
		if (wr.buffer_en)
			data_q <= data_rev;
		else if (count_q != 3'd0)
			data_q <= data_q >> 8;
	end

	assign beat.valid  = (count_q != 3'd0);
	assign beat.data   = data_q[7:0];
	// Full until the last byte has been handed over
	assign buffer_full = (count_q != 3'd0);

endmodule
